//--- dfxsecure_pkg.sv
`default_nettype none

// ****************************************************************************
// shared widths and policy codes for the debug-security corner
// ****************************************************************************

package dfxsecure_pkg;

   // policy bus width, identical for every block on the soc
   localparam int policy_width = 4;

   // one matrix row per policy code
   localparam int num_policies = 16;

   // control bits at the bottom of each matrix row
   // bit 0 customer-disable, bit 1 all-disable, feature enables above
   localparam int row_ctl_bits = 2;

   // one visa trace lane carries a byte
   localparam int lane_width = 8;

   // secure policy and oem strap share this encoding
   typedef logic [policy_width-1:0] policy_t;

   // ************************************************************************
   // named policy codes
   // ************************************************************************

   // power-on value, nothing unlocked
   localparam policy_t policy_security_locked = 4'h0;

   // oem debug window, the usual target of the sideband override
   localparam policy_t policy_oem_unlocked = 4'h5;

   // part fused off, last row of the matrix
   localparam policy_t policy_part_disabled = 4'hf;

endpackage

`default_nettype wire

//--- dfxsecure_plugin.sv
`timescale 1ns/100ps
`default_nettype none

// ****************************************************************************
// policy capture, matrix lookup, oem sideband override, early-boot row
// ****************************************************************************

module dfxsecure_plugin
#(
   parameter int NUM_FEATURES = 6,
   parameter bit USE_SB_OVR = 1'b1,
   // row k sits at bits [k*row width +: row width]
   parameter logic [dfxsecure_pkg::num_policies*(NUM_FEATURES+dfxsecure_pkg::row_ctl_bits)-1:0]
      POLICY_MATRIX = {dfxsecure_pkg::num_policies{{NUM_FEATURES{1'b0}}, 2'b11}},
   parameter logic [NUM_FEATURES+dfxsecure_pkg::row_ctl_bits-1:0]
      EARLYBOOT_ROW = {{NUM_FEATURES{1'b1}}, 2'b00}
)
(
   input  wire logic                                          ftap_tck,
   input  wire logic                                          rst_n,
   input  wire dfxsecure_pkg::policy_t                        fdfx_secure_policy,
   input  wire logic                                          fdfx_policy_update,
   input  wire logic                                          fdfx_earlyboot_exit,
   input  wire logic [NUM_FEATURES+dfxsecure_pkg::row_ctl_bits-1:0] sb_policy_ovr_value,
   input  wire dfxsecure_pkg::policy_t                        oem_secure_policy,
   output logic      [NUM_FEATURES-1:0]                       dfxsecure_feature_en,
   output logic                                               visa_all_dis,
   output logic                                               visa_customer_dis,
   output logic                                               policy_update_seen
);

   import dfxsecure_pkg::*;

   localparam int ROW_W = NUM_FEATURES + row_ctl_bits;

   typedef logic [ROW_W-1:0] row_t;

   policy_t policy_q;
   row_t    matrix_row;
   row_t    ovr_row;
   row_t    active_row;
   logic    oem_select;

   // ************************************************************************
   // policy capture
   // ************************************************************************

   // flop replaces the old level latch, update strobe acts as enable
   always_ff @(posedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         policy_q           <= policy_security_locked;
         policy_update_seen <= 1'b0;
      end
      else
      begin
         if (fdfx_policy_update)
         begin
            policy_q <= fdfx_secure_policy;
         end
         // pulse follows the capture edge, consumers clear sticky state on it
         policy_update_seen <= fdfx_policy_update;
      end
   end

   // ************************************************************************
   // row selection
   // ************************************************************************

   // plain lookup, one row per code
   assign matrix_row = POLICY_MATRIX[int'(policy_q)*ROW_W +: ROW_W];

   // oem strap must name the captured policy before the sideband row applies
   assign oem_select = USE_SB_OVR && (oem_secure_policy == policy_q);
   assign ovr_row    = oem_select ? sb_policy_ovr_value : matrix_row;

   // early boot window overrides both the matrix and the sideband
   assign active_row = fdfx_earlyboot_exit ? ovr_row : EARLYBOOT_ROW;

   // unpack the row
   assign visa_customer_dis    = active_row[0];
   assign visa_all_dis         = active_row[1];
   assign dfxsecure_feature_en = active_row[ROW_W-1:row_ctl_bits];

   // ************************************************************************
   // checks
   // ************************************************************************

   // policy only moves on an update strobe
   a_policy_hold: assert property (@(posedge ftap_tck) disable iff (!rst_n)
      !fdfx_policy_update |=> $stable(policy_q));

   // port view of the early boot row, ordering of the unpacked bits
   a_earlyboot_row: assert property (@(posedge ftap_tck) disable iff (!rst_n)
      !fdfx_earlyboot_exit |->
         ({dfxsecure_feature_en, visa_all_dis, visa_customer_dis} == EARLYBOOT_ROW));

   // interesting corners
   c_oem_override: cover property (@(posedge ftap_tck) disable iff (!rst_n)
      fdfx_earlyboot_exit && oem_select && (policy_q == policy_oem_unlocked));
   c_part_disabled: cover property (@(posedge ftap_tck) disable iff (!rst_n)
      fdfx_policy_update && (fdfx_secure_policy == policy_part_disabled));

endmodule

`default_nettype wire

//--- dfxsecure_feature_gate.sv
`timescale 1ns/100ps
`default_nettype none

// ****************************************************************************
// per-feature debug request arbitration
// ****************************************************************************

module dfxsecure_feature_gate
#(
   parameter int NUM_FEATURES = 6
)
(
   input  wire logic                    ftap_tck,
   input  wire logic                    rst_n,
   input  wire logic [NUM_FEATURES-1:0] dbg_req,
   input  wire logic [NUM_FEATURES-1:0] dfxsecure_feature_en,
   input  wire logic                    policy_update_seen,
   output logic      [NUM_FEATURES-1:0] dbg_grant,
   output logic      [NUM_FEATURES-1:0] dbg_deny,
   output logic      [NUM_FEATURES-1:0] deny_sticky
);

   typedef logic [NUM_FEATURES-1:0] feat_t;

   feat_t grant_d;
   feat_t deny_d;

   // request strobes split by the current enable level
   assign grant_d = dbg_req & dfxsecure_feature_en;
   assign deny_d  = dbg_req & ~dfxsecure_feature_en;

   // ************************************************************************
   // answer pulses and sticky deny flags
   // ************************************************************************

   always_ff @(posedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dbg_grant   <= '0;
         dbg_deny    <= '0;
         deny_sticky <= '0;
      end
      else
      begin
         // one cycle answer, strobes are never held
         dbg_grant <= grant_d;
         dbg_deny  <= deny_d;
         // new policy wipes the history, even a deny in the same cycle
         if (policy_update_seen)
         begin
            deny_sticky <= '0;
         end
         else
         begin
            deny_sticky <= deny_sticky | deny_d;
         end
      end
   end

   // a feature is answered one way only
   a_grant_deny_excl: assert property (@(posedge ftap_tck) disable iff (!rst_n)
      (dbg_grant & dbg_deny) == '0);

endmodule

`default_nettype wire

//--- dfxsecure_trace_gate.sv
`timescale 1ns/100ps
`default_nettype none

// ****************************************************************************
// visa trace lane masking
// ****************************************************************************

module dfxsecure_trace_gate
#(
   parameter int VISA_LANES     = 8,
   parameter int CUSTOMER_LANES = 4
)
(
   input  wire logic                                             ftap_tck,
   input  wire logic                                             rst_n,
   input  wire logic [VISA_LANES*dfxsecure_pkg::lane_width-1:0]  visa_lanes_in,
   input  wire logic                                             visa_all_dis,
   input  wire logic                                             visa_customer_dis,
   output logic      [VISA_LANES*dfxsecure_pkg::lane_width-1:0]  visa_lanes_out
);

   import dfxsecure_pkg::*;

   typedef logic [lane_width-1:0] lane_t;

   lane_t [VISA_LANES-1:0] lanes_d;
   lane_t [VISA_LANES-1:0] lanes_q;
   logic  [VISA_LANES-1:0] lane_keep;

   // flat bus viewed lane by lane
   assign lanes_d = visa_lanes_in;

   // ************************************************************************
   // lane mask
   // ************************************************************************

   // lower lanes stay visible to the customer, upper ones are hidden
   always_comb
   begin
      for (int i = 0; i < VISA_LANES; i++)
      begin
         lane_keep[i] = !visa_all_dis && !(visa_customer_dis && (i >= CUSTOMER_LANES));
      end
   end

   always_ff @(posedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lanes_q <= '0;
      end
      else
      begin
         for (int i = 0; i < VISA_LANES; i++)
         begin
            lanes_q[i] <= lane_keep[i] ? lanes_d[i] : '0;
         end
      end
   end

   assign visa_lanes_out = lanes_q;

   // all-disable blanks the whole trace on the following cycle
   a_all_dis_blank: assert property (@(posedge ftap_tck) disable iff (!rst_n)
      visa_all_dis |=> (visa_lanes_out == '0));

endmodule

`default_nettype wire

//--- dfxsecure_top.sv
`timescale 1ns/100ps
`default_nettype none

// ****************************************************************************
// debug-security corner, plugin plus its two consumers
// ****************************************************************************

module dfxsecure_top
#(
   parameter int NUM_FEATURES   = 6,
   parameter bit USE_SB_OVR     = 1'b1,
   parameter int VISA_LANES     = 8,
   parameter int CUSTOMER_LANES = 4,
   // default matrix locks every policy, soc integration supplies the real one
   parameter logic [dfxsecure_pkg::num_policies*(NUM_FEATURES+dfxsecure_pkg::row_ctl_bits)-1:0]
      POLICY_MATRIX = {dfxsecure_pkg::num_policies{{NUM_FEATURES{1'b0}}, 2'b11}},
   // early boot opens every feature and both visa views
   parameter logic [NUM_FEATURES+dfxsecure_pkg::row_ctl_bits-1:0]
      EARLYBOOT_ROW = {{NUM_FEATURES{1'b1}}, 2'b00}
)
(
   input  wire logic                                             ftap_tck,
   input  wire logic                                             rst_n,
   input  wire dfxsecure_pkg::policy_t                           fdfx_secure_policy,
   input  wire logic                                             fdfx_policy_update,
   input  wire logic                                             fdfx_earlyboot_exit,
   input  wire logic [NUM_FEATURES+dfxsecure_pkg::row_ctl_bits-1:0] sb_policy_ovr_value,
   input  wire dfxsecure_pkg::policy_t                           oem_secure_policy,
   input  wire logic [NUM_FEATURES-1:0]                          dbg_req,
   input  wire logic [VISA_LANES*dfxsecure_pkg::lane_width-1:0]  visa_lanes_in,
   output logic      [NUM_FEATURES-1:0]                          dfxsecure_feature_en,
   output logic                                                  visa_all_dis,
   output logic                                                  visa_customer_dis,
   output logic                                                  policy_update_seen,
   output logic      [NUM_FEATURES-1:0]                          dbg_grant,
   output logic      [NUM_FEATURES-1:0]                          dbg_deny,
   output logic      [NUM_FEATURES-1:0]                          deny_sticky,
   output logic      [VISA_LANES*dfxsecure_pkg::lane_width-1:0]  visa_lanes_out
);

   // policy decode, its outputs double as top-level ports
   dfxsecure_plugin #(
      .NUM_FEATURES  (NUM_FEATURES),
      .USE_SB_OVR    (USE_SB_OVR),
      .POLICY_MATRIX (POLICY_MATRIX),
      .EARLYBOOT_ROW (EARLYBOOT_ROW)
   ) u_plugin (
      .ftap_tck             (ftap_tck),
      .rst_n                (rst_n),
      .fdfx_secure_policy   (fdfx_secure_policy),
      .fdfx_policy_update   (fdfx_policy_update),
      .fdfx_earlyboot_exit  (fdfx_earlyboot_exit),
      .sb_policy_ovr_value  (sb_policy_ovr_value),
      .oem_secure_policy    (oem_secure_policy),
      .dfxsecure_feature_en (dfxsecure_feature_en),
      .visa_all_dis         (visa_all_dis),
      .visa_customer_dis    (visa_customer_dis),
      .policy_update_seen   (policy_update_seen)
   );

   // debug access requests
   dfxsecure_feature_gate #(
      .NUM_FEATURES (NUM_FEATURES)
   ) u_feature_gate (
      .ftap_tck             (ftap_tck),
      .rst_n                (rst_n),
      .dbg_req              (dbg_req),
      .dfxsecure_feature_en (dfxsecure_feature_en),
      .policy_update_seen   (policy_update_seen),
      .dbg_grant            (dbg_grant),
      .dbg_deny             (dbg_deny),
      .deny_sticky          (deny_sticky)
   );

   // visa trace
   dfxsecure_trace_gate #(
      .VISA_LANES     (VISA_LANES),
      .CUSTOMER_LANES (CUSTOMER_LANES)
   ) u_trace_gate (
      .ftap_tck          (ftap_tck),
      .rst_n             (rst_n),
      .visa_lanes_in     (visa_lanes_in),
      .visa_all_dis      (visa_all_dis),
      .visa_customer_dis (visa_customer_dis),
      .visa_lanes_out    (visa_lanes_out)
   );

endmodule

`default_nettype wire

//--- tb_dfxsecure_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dfxsecure_checker
#(
   parameter int NUM_FEATURES   = 6,
   parameter int VISA_LANES     = 8,
   parameter int CUSTOMER_LANES = 4
)
(
   input  wire logic                      ftap_tck,
   input  wire logic                      rst_n,
   input  wire logic                      chk_go,
   input  wire logic [31:0]               chk_idx,
   input  wire logic [NUM_FEATURES-1:0]   feature_en,
   input  wire logic                      all_dis,
   input  wire logic                      cust_dis,
   input  wire logic                      update_seen,
   input  wire logic [NUM_FEATURES-1:0]   grant,
   input  wire logic [NUM_FEATURES-1:0]   deny,
   input  wire logic [NUM_FEATURES-1:0]   sticky,
   input  wire logic [VISA_LANES*8-1:0]   lanes_in,
   input  wire logic [VISA_LANES*8-1:0]   lanes_out,
   output int                             err_count,
   output int                             test_count
);

   // expected columns of the data file
   string name_q[$];
   int    upd_q[$];
   int    fe_q[$];
   int    all_q[$];
   int    cust_q[$];
   int    grant_q[$];
   int    deny_q[$];
   int    sticky_q[$];

   logic                    lane_pend;
   int                      pend_idx;
   logic                    pend_bad;
   logic                    bad_now;
   logic [VISA_LANES*8-1:0] pend_lanes;

   initial
   begin
      int    fd;
      int    n;
      string line;
      string nm;
      int    d0, d1, d2, d3, d4, d5, d6;
      int    e0, e1, e2, e3, e4, e5;
      err_count  = 0;
      test_count = 0;
      lane_pend  = 1'b0;
      fd = $fopen("dfxsecure_input.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  nm, d0, d1, d2, d3, d4, d5, d6, e0, e1, e2, e3, e4, e5);
               if (n == 14)
               begin
                  name_q.push_back(nm);
                  upd_q.push_back(d1);
                  fe_q.push_back(e0);
                  all_q.push_back(e1);
                  cust_q.push_back(e2);
                  grant_q.push_back(e3);
                  deny_q.push_back(e4);
                  sticky_q.push_back(e5);
               end
            end
         end
         $fclose(fd);
      end
   end

   // lanes below CUSTOMER_LANES survive customer-disable, nothing survives all-disable
   function automatic logic [VISA_LANES*8-1:0] mask_lanes(input logic [VISA_LANES*8-1:0] din,
                                                         input logic a, input logic c);
      logic [VISA_LANES*8-1:0] m;
      m = '0;
      for (int i = 0; i < VISA_LANES; i++)
      begin
         if (!a && !(c && i >= CUSTOMER_LANES))
         begin
            m[i*8 +: 8] = din[i*8 +: 8];
         end
      end
      return m;
   endfunction

   task automatic compare_field(input string tname, input string field,
                                input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("error %s %s expected %h actual %h", tname, field, exp, act);
         err_count = err_count + 1;
         bad_now   = 1'b1;
      end
   endtask

   // ************************************************************************
   // sampling at the rising edge, flop outputs still hold the previous cycle
   // ************************************************************************

   always @(posedge ftap_tck)
   begin
      if (rst_n)
      begin
         // lane data captured one edge ago closes the previous test
         if (lane_pend)
         begin
            bad_now = pend_bad;
            compare_field(name_q[pend_idx], "visa_lanes_out",
               64'(mask_lanes(pend_lanes, all_q[pend_idx][0], cust_q[pend_idx][0])),
               64'(lanes_out));
            // answer and update pulses last a single cycle
            compare_field(name_q[pend_idx], "dbg_grant end", 64'(0), 64'(grant));
            compare_field(name_q[pend_idx], "dbg_deny end", 64'(0), 64'(deny));
            compare_field(name_q[pend_idx], "policy_update_seen end", 64'(0),
               64'(update_seen));
            if (bad_now)
            begin
               $display("test %s failed", name_q[pend_idx]);
            end
            else
            begin
               $display("test %s ok", name_q[pend_idx]);
            end
            test_count = test_count + 1;
            lane_pend  = 1'b0;
         end
         if (chk_go)
         begin
            if (chk_idx >= name_q.size())
            begin
               $display("test index %0d has no expected values in the data file", chk_idx);
               err_count  = err_count + 1;
               test_count = test_count + 1;
            end
            else
            begin
               bad_now = 1'b0;
               compare_field(name_q[chk_idx], "feature_en", 64'(fe_q[chk_idx]), 64'(feature_en));
               compare_field(name_q[chk_idx], "all_dis", 64'(all_q[chk_idx]), 64'(all_dis));
               compare_field(name_q[chk_idx], "customer_dis", 64'(cust_q[chk_idx]),
                  64'(cust_dis));
               // pulse follows a capture edge, so it mirrors the update column
               compare_field(name_q[chk_idx], "policy_update_seen", 64'(upd_q[chk_idx]),
                  64'(update_seen));
               compare_field(name_q[chk_idx], "dbg_grant", 64'(grant_q[chk_idx]), 64'(grant));
               compare_field(name_q[chk_idx], "dbg_deny", 64'(deny_q[chk_idx]), 64'(deny));
               compare_field(name_q[chk_idx], "deny_sticky", 64'(sticky_q[chk_idx]),
                  64'(sticky));
               pend_bad   = bad_now;
               pend_idx   = chk_idx;
               pend_lanes = lanes_in;
               lane_pend  = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_dfxsecure.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dfxsecure;

   import dfxsecure_pkg::*;

   localparam int NUM_FEATURES   = 6;
   localparam int VISA_LANES     = 8;
   localparam int CUSTOMER_LANES = 4;
   localparam int ROW_W          = NUM_FEATURES + row_ctl_bits;
   localparam int LANE_BITS      = VISA_LANES * lane_width;
   localparam logic [31:0] SEED  = 32'h5a26_5d71;

   // row k is k times 8'h1d, truncated to the row width
   function automatic logic [num_policies*ROW_W-1:0] build_matrix();
      logic [num_policies*ROW_W-1:0] m;
      m = '0;
      for (int k = 0; k < num_policies; k++)
      begin
         m[k*ROW_W +: ROW_W] = ROW_W'(k * 8'h1d);
      end
      return m;
   endfunction

   localparam logic [num_policies*ROW_W-1:0] MATRIX = build_matrix();
   localparam logic [ROW_W-1:0] EB_ROW = {{NUM_FEATURES{1'b1}}, 2'b00};

   logic                    ftap_tck;
   logic                    rst_n;
   policy_t                 policy;
   logic                    upd;
   logic                    eb_exit;
   policy_t                 strap;
   logic [ROW_W-1:0]        sb_row;
   logic [NUM_FEATURES-1:0] dbg_req;
   logic [LANE_BITS-1:0]    lanes_in;
   logic [NUM_FEATURES-1:0] feature_en;
   logic                    all_dis;
   logic                    cust_dis;
   logic                    update_seen;
   logic [NUM_FEATURES-1:0] grant;
   logic [NUM_FEATURES-1:0] deny;
   logic [NUM_FEATURES-1:0] sticky;
   logic [LANE_BITS-1:0]    lanes_out;

   logic chk_go;
   int   chk_idx;
   int   err_count;
   int   test_count;
   int   num_tests;

   // stimulus columns of the data file
   policy_t                 pol_q[$];
   logic                    upd_q[$];
   logic                    exit_q[$];
   policy_t                 strap_q[$];
   logic [ROW_W-1:0]        sb_q[$];
   logic [NUM_FEATURES-1:0] req_q[$];
   logic [31:0]             lseed_q[$];

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic read_stimulus();
      int    fd;
      int    n;
      string line;
      string nm;
      int    p, u, e, s, sb, rq, ls;
      fd = $fopen("dfxsecure_input.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h", nm, p, u, e, s, sb, rq, ls);
               if (n == 8)
               begin
                  pol_q.push_back(policy_t'(p));
                  upd_q.push_back(u[0]);
                  exit_q.push_back(e[0]);
                  strap_q.push_back(policy_t'(s));
                  sb_q.push_back(ROW_W'(sb));
                  req_q.push_back(NUM_FEATURES'(rq));
                  lseed_q.push_back(32'(ls));
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ************************************************************************
   // clock, DUT, checker
   // ************************************************************************

   initial
   begin
      ftap_tck = 1'b0;
      forever
      begin
         #4 ftap_tck = ~ftap_tck;
      end
   end

   dfxsecure_top #(
      .NUM_FEATURES   (NUM_FEATURES),
      .USE_SB_OVR     (1'b1),
      .VISA_LANES     (VISA_LANES),
      .CUSTOMER_LANES (CUSTOMER_LANES),
      .POLICY_MATRIX  (MATRIX),
      .EARLYBOOT_ROW  (EB_ROW)
   ) DUT (
      .ftap_tck             (ftap_tck),
      .rst_n                (rst_n),
      .fdfx_secure_policy   (policy),
      .fdfx_policy_update   (upd),
      .fdfx_earlyboot_exit  (eb_exit),
      .sb_policy_ovr_value  (sb_row),
      .oem_secure_policy    (strap),
      .dbg_req              (dbg_req),
      .visa_lanes_in        (lanes_in),
      .dfxsecure_feature_en (feature_en),
      .visa_all_dis         (all_dis),
      .visa_customer_dis    (cust_dis),
      .policy_update_seen   (update_seen),
      .dbg_grant            (grant),
      .dbg_deny             (deny),
      .deny_sticky          (sticky),
      .visa_lanes_out       (lanes_out)
   );

   tb_dfxsecure_checker #(
      .NUM_FEATURES   (NUM_FEATURES),
      .VISA_LANES     (VISA_LANES),
      .CUSTOMER_LANES (CUSTOMER_LANES)
   ) u_checker (
      .ftap_tck    (ftap_tck),
      .rst_n       (rst_n),
      .chk_go      (chk_go),
      .chk_idx     (chk_idx),
      .feature_en  (feature_en),
      .all_dis     (all_dis),
      .cust_dis    (cust_dis),
      .update_seen (update_seen),
      .grant       (grant),
      .deny        (deny),
      .sticky      (sticky),
      .lanes_in    (lanes_in),
      .lanes_out   (lanes_out),
      .err_count   (err_count),
      .test_count  (test_count)
   );

   // ************************************************************************
   // stimulus
   // ************************************************************************

   initial
   begin
      logic [31:0] state;
      logic [31:0] lo;
      rst_n     = 1'b0;
      policy    = '0;
      upd       = 1'b0;
      eb_exit   = 1'b0;
      strap     = 4'he;
      sb_row    = '0;
      dbg_req   = '0;
      lanes_in  = '0;
      chk_go    = 1'b0;
      chk_idx   = 0;
      num_tests = 0;
      read_stimulus();
      if (pol_q.size() == 0)
      begin
         $display("no tests could be read from dfxsecure_input.txt");
         $display("SIMULATION FAILED");
         $finish;
      end
      else
      begin
         num_tests = pol_q.size();
         repeat (8) @(posedge ftap_tck);
         @(negedge ftap_tck);
         rst_n = 1'b1;
         state = SEED;
         for (int k = 0; k < num_tests; k++)
         begin
            // first half of a test, strobes and levels
            @(negedge ftap_tck);
            chk_go   = 1'b0;
            policy   = pol_q[k];
            upd      = upd_q[k];
            eb_exit  = exit_q[k];
            strap    = strap_q[k];
            sb_row   = sb_q[k];
            dbg_req  = req_q[k];
            lanes_in = '0;
            // second half, strobes drop and trace data runs under the new row
            @(negedge ftap_tck);
            upd      = 1'b0;
            dbg_req  = '0;
            state    = xorshift(state ^ lseed_q[k]);
            lo       = state;
            state    = xorshift(state);
            lanes_in = {state, lo};
            chk_idx  = k;
            chk_go   = 1'b1;
         end
         @(negedge ftap_tck);
         chk_go = 1'b0;
         wait (test_count == num_tests);
         $display("tests run %0d, errors %0d", test_count, err_count);
         if (err_count == 0)
         begin
            $display("SIMULATION PASSED");
         end
         else
         begin
            $display("SIMULATION FAILED");
         end
         $finish;
      end
   end

   // two cycles per test, plus margin
   initial
   begin
      wait (num_tests > 0);
      #((num_tests + 20) * 8 * 8);
      $display("the run timed out before all tests were checked");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- dfxsecure_input.txt
# name policy update exit strap sb_row dbg_req lane_seed | exp: feature_en all cust grant deny sticky
# all hex, policy_oem_unlocked is 5, policy_part_disabled is f, strap e never matches
eb_pol3      3 0 0 e 00 00 00000011  3f 0 0 00 00 00
eb_pol9_upd  9 1 0 e 00 00 00000022  3f 0 0 00 00 00
eb_req       9 0 0 e 00 2a 00000033  3f 0 0 2a 00 00
exit_row9    9 0 1 e 00 00 00000044  01 0 1 00 00 00
upd_pol1     1 1 1 e 00 00 00000055  07 0 1 00 00 00
req_pol1     1 0 1 e 00 3c 00000066  07 0 1 04 38 38
hold_pol6    6 0 1 e 00 00 00000077  07 0 1 00 00 38
upd_pol6     6 1 1 e 00 00 00000088  2b 1 0 00 00 38
req_pol6     6 0 1 e 00 15 00000099  2b 1 0 01 14 14
oem_match    6 0 1 6 91 00 000000aa  24 0 1 00 00 14
oem_req      6 0 1 6 91 24 000000bb  24 0 1 24 00 14
oem_miss     6 0 1 e 91 00 000000cc  2b 1 0 00 00 14
upd_oem5     5 1 1 5 fc 00 000000dd  3f 0 0 00 00 14
upd_pol15    f 1 1 e 00 00 000000ee  2c 1 1 00 00 00
upd_pol12    c 1 1 e 00 00 000000ff  17 0 0 00 00 00
req_pol12    c 0 1 e 00 3f 00000101  17 0 0 17 28 28
upd_pol0     0 1 1 e 00 00 00000202  00 0 0 00 00 28
req_pol0     0 0 1 e 00 01 00000303  00 0 0 00 01 01
upd_pol2     2 1 1 e 00 00 00000404  0e 1 0 00 00 01
upd_pol3     3 1 1 e 00 00 00000505  15 1 1 00 00 00

//--- vlog.f
dfxsecure_pkg.sv
dfxsecure_plugin.sv
dfxsecure_feature_gate.sv
dfxsecure_trace_gate.sv
dfxsecure_top.sv
tb_dfxsecure_checker.sv
tb_dfxsecure.sv

//--- Makefile
TOP = tb_dfxsecure

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)
	verilator --lint-only -f vlog.f --top-module dfxsecure_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
